//--- mem_pkg.sv
/*
 * Memory subsystem package
 * Sizes, opcode and lane-state encodings, and the command, lane request
 * and response structs shared by the dispatcher, lanes and arbiter
 */
`default_nettype none

package mem_pkg;

    // ======================================================================
    // Sizes
    // ======================================================================
    localparam int LANE_COUNT = 2;
    // Lane index doubles as the AXI ID
    localparam int LANE_IDX_W = 1;
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;

    // ======================================================================
    // Encodings
    // ======================================================================
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    typedef enum logic [1:0] {
        LANE_IDLE = 2'd0,
        LANE_PEND = 2'd1,
        LANE_WAIT = 2'd2
    } lane_state_e;

    // ======================================================================
    // Bundles
    // ======================================================================
    typedef struct packed {
        mem_op_e             op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
        logic [STRB_W-1:0]   wstrb;
    } mem_cmd_t;

    typedef struct packed {
        logic                pend;
        mem_cmd_t            cmd;
    } lane_req_t;

    typedef struct packed {
        logic [LANE_IDX_W-1:0] tag;
        mem_op_e               op;
        logic [DATA_W-1:0]     rdata;
        logic [1:0]            resp;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- req_dispatch.sv
/*
 * Command dispatcher
 * Runs the four-phase req/ack handshake and loads each accepted
 * command into the lowest-numbered idle issue lane
 */
`timescale 1ns/1ps
`default_nettype none

module req_dispatch (
    input  wire                                aclk,
    input  wire                                reset,
    input  wire                                cmd_req,
    input  wire  mem_pkg::mem_cmd_t            cmd,
    input  wire  [mem_pkg::LANE_COUNT-1:0]     lane_busy,
    output logic                               cmd_ack,
    output logic [mem_pkg::LANE_COUNT-1:0]     lane_load,
    output mem_pkg::mem_cmd_t                  lane_cmd
);
    import mem_pkg::*;

    typedef enum logic {
        DISP_IDLE = 1'b0,
        DISP_ACK  = 1'b1
    } disp_state_e;

    disp_state_e             state;
    logic [LANE_COUNT-1:0]   free_onehot;
    logic                    any_free;

    // Priority encoder, lane 0 wins
    always_comb begin
        free_onehot = '0;
        any_free    = 1'b0;
        for (int i = 0; i < LANE_COUNT; i++) begin
            if (!lane_busy[i] && !any_free) begin
                free_onehot[i] = 1'b1;
                any_free       = 1'b1;
            end
        end
    end

    // Ack is high for as long as the FSM sits in DISP_ACK
    assign cmd_ack = (state == DISP_ACK);

    always_ff @(posedge aclk) begin
        if (reset) begin
            state     <= DISP_IDLE;
            lane_load <= '0;
        end else begin
            lane_load <= '0;
            case (state)
                DISP_IDLE: begin
                    if (cmd_req && any_free) begin
                        lane_load <= free_onehot;
                        state     <= DISP_ACK;
                    end
                end
                // Wait for the requester to drop req
                DISP_ACK: begin
                    if (!cmd_req) begin
                        state <= DISP_IDLE;
                    end
                end
                default: state <= DISP_IDLE;
            endcase
        end
    end

    // Command copy goes out with the load pulse
    always_ff @(posedge aclk) begin
        if (state == DISP_IDLE && cmd_req && any_free) begin
            lane_cmd <= cmd;
        end
    end

endmodule

`default_nettype wire

//--- mem_lane.sv
/*
 * Issue lane
 * Holds one command from load through AXI address acceptance
 * to the return of its response
 */
`timescale 1ns/1ps
`default_nettype none

module mem_lane (
    input  wire                    aclk,
    input  wire                    reset,
    input  wire                    load,
    input  wire  mem_pkg::mem_cmd_t cmd,
    input  wire                    grant,
    input  wire                    done,
    output mem_pkg::lane_req_t     req,
    output logic                   busy
);
    import mem_pkg::*;

    lane_state_e   state;
    lane_state_e   state_nxt;
    mem_cmd_t      cmd_q;

    // ======================================================================
    // Lane FSM
    // ======================================================================

    always_comb begin
        state_nxt = state;
        case (state)
            LANE_IDLE: begin
                if (load) begin
                    state_nxt = LANE_PEND;
                end
            end
            // Waiting for the arbiter to put it on AXI
            LANE_PEND: begin
                if (grant) begin
                    state_nxt = LANE_WAIT;
                end
            end
            // Address accepted, response outstanding
            LANE_WAIT: begin
                if (done) begin
                    state_nxt = LANE_IDLE;
                end
            end
            default: state_nxt = LANE_IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= LANE_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ======================================================================
    // Command storage
    // ======================================================================

    // Captured only on load so write data stays put until the lane frees up
    always_ff @(posedge aclk) begin
        if (state == LANE_IDLE && load) begin
            cmd_q <= cmd;
        end
    end

    // ======================================================================
    // Outputs
    // ======================================================================

    // Pend only while un-issued, a granted lane never asks again
    always_comb begin
        req.pend = (state == LANE_PEND);
        req.cmd  = cmd_q;
    end

    assign busy = (state != LANE_IDLE);

endmodule

`default_nettype wire

//--- axi_arbiter.sv
/*
 * AXI arbiter
 * Round-robin issue of pending lanes as single-beat AXI reads and writes,
 * and return of R and B beats as a tagged response stream
 */
`timescale 1ns/1ps
`default_nettype none

module axi_arbiter (
    input  wire                                  aclk,
    input  wire                                  reset,
    input  wire  mem_pkg::lane_req_t             lane_reqs [mem_pkg::LANE_COUNT],
    output logic [mem_pkg::LANE_COUNT-1:0]       lane_grant,
    output logic [mem_pkg::LANE_COUNT-1:0]       lane_done,
    // AR
    output logic [mem_pkg::LANE_IDX_W-1:0]       arid,
    output logic [mem_pkg::ADDR_W-1:0]           araddr,
    output logic                                 arvalid,
    input  wire                                  arready,
    // AW
    output logic [mem_pkg::LANE_IDX_W-1:0]       awid,
    output logic [mem_pkg::ADDR_W-1:0]           awaddr,
    output logic                                 awvalid,
    input  wire                                  awready,
    // W
    output logic [mem_pkg::DATA_W-1:0]           wdata,
    output logic [mem_pkg::STRB_W-1:0]           wstrb,
    output logic                                 wvalid,
    input  wire                                  wready,
    // R
    input  wire  [mem_pkg::LANE_IDX_W-1:0]       rid,
    input  wire  [mem_pkg::DATA_W-1:0]           rdata,
    input  wire  [1:0]                           rresp,
    input  wire                                  rvalid,
    output logic                                 rready,
    // B
    input  wire  [mem_pkg::LANE_IDX_W-1:0]       bid,
    input  wire  [1:0]                           bresp,
    input  wire                                  bvalid,
    output logic                                 bready,
    // Response stream
    output logic                                 rsp_valid,
    output mem_pkg::mem_rsp_t                    rsp,
    input  wire                                  rsp_ready
);
    import mem_pkg::*;

    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_ADDR = 1'b1
    } arb_state_e;

    arb_state_e              state;
    logic [LANE_IDX_W-1:0]   rr_ptr;
    logic [LANE_IDX_W-1:0]   pick_idx;
    logic                    pick_found;
    int                      cand;
    logic [LANE_IDX_W-1:0]   sel_idx;
    mem_op_e                 cur_op;
    logic [ADDR_W-1:0]       addr_q;
    logic                    addr_fin;
    logic                    grant_now;
    logic                    can_take;
    logic                    r_hs;
    logic                    b_hs;

    // ======================================================================
    // Request side
    // ======================================================================

    // Search starts at the lane after the last one granted
    always_comb begin
        pick_found = 1'b0;
        pick_idx   = rr_ptr;
        cand       = 0;
        for (int i = 0; i < LANE_COUNT; i++) begin
            cand = (int'(rr_ptr) + i) % LANE_COUNT;
            if (!pick_found && lane_reqs[cand].pend) begin
                pick_found = 1'b1;
                pick_idx   = LANE_IDX_W'(cand);
            end
        end
    end

    // A low valid in ARB_ADDR means that channel was already taken
    always_comb begin
        if (cur_op == OP_WRITE) begin
            addr_fin = (!awvalid || awready) && (!wvalid || wready);
        end else begin
            addr_fin = arready;
        end
    end

    assign grant_now = (state == ARB_ADDR) && addr_fin;

    always_comb begin
        lane_grant = '0;
        if (grant_now) begin
            lane_grant[sel_idx] = 1'b1;
        end
    end

    assign arid   = sel_idx;
    assign awid   = sel_idx;
    assign araddr = addr_q;
    assign awaddr = addr_q;

    always_ff @(posedge aclk) begin
        if (reset) begin
            state   <= ARB_IDLE;
            rr_ptr  <= '0;
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (pick_found) begin
                        arvalid <= (lane_reqs[pick_idx].cmd.op == OP_READ);
                        awvalid <= (lane_reqs[pick_idx].cmd.op == OP_WRITE);
                        wvalid  <= (lane_reqs[pick_idx].cmd.op == OP_WRITE);
                        state   <= ARB_ADDR;
                    end
                end
                ARB_ADDR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                    end
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if (addr_fin) begin
                        state  <= ARB_IDLE;
                        rr_ptr <= (sel_idx == LANE_IDX_W'(LANE_COUNT - 1)) ?
                                  '0 : sel_idx + 1'b1;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Address and data payload for the selected lane
    always_ff @(posedge aclk) begin
        if (state == ARB_IDLE && pick_found) begin
            sel_idx <= pick_idx;
            cur_op  <= lane_reqs[pick_idx].cmd.op;
            addr_q  <= lane_reqs[pick_idx].cmd.addr;
            wdata   <= lane_reqs[pick_idx].cmd.wdata;
            wstrb   <= lane_reqs[pick_idx].cmd.wstrb;
        end
    end

    // ======================================================================
    // Response side
    // ======================================================================

    // Room in the response register, now or after this cycle's pop
    assign can_take = !rsp_valid || rsp_ready;
    // R wins over B
    assign rready   = rvalid && can_take;
    assign bready   = bvalid && !rvalid && can_take;
    assign r_hs     = rvalid && rready;
    assign b_hs     = bvalid && bready;

    always_ff @(posedge aclk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
            lane_done <= '0;
        end else begin
            lane_done <= '0;
            if (r_hs) begin
                rsp_valid      <= 1'b1;
                lane_done[rid] <= 1'b1;
            end else if (b_hs) begin
                rsp_valid      <= 1'b1;
                lane_done[bid] <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (r_hs) begin
            rsp <= '{tag: rid, op: OP_READ, rdata: rdata, resp: rresp};
        end else if (b_hs) begin
            rsp <= '{tag: bid, op: OP_WRITE, rdata: '0, resp: bresp};
        end
    end

endmodule

`default_nettype wire

//--- core_top.sv
/*
 * Memory subsystem top
 * Dispatcher, issue lanes and AXI arbiter, with flat single-beat AXI ports
 */
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  wire                              aclk,
    input  wire                              reset,
    // Command port
    input  wire                              cmd_req,
    input  wire  mem_pkg::mem_cmd_t          cmd,
    output logic                             cmd_ack,
    // Response stream
    output logic                             rsp_valid,
    output mem_pkg::mem_rsp_t                rsp,
    input  wire                              rsp_ready,
    // AXI read address
    output logic [mem_pkg::LANE_IDX_W-1:0]   arid,
    output logic [mem_pkg::ADDR_W-1:0]       araddr,
    output logic                             arvalid,
    input  wire                              arready,
    // AXI read data
    input  wire  [mem_pkg::LANE_IDX_W-1:0]   rid,
    input  wire  [mem_pkg::DATA_W-1:0]       rdata,
    input  wire  [1:0]                       rresp,
    input  wire                              rvalid,
    output logic                             rready,
    // AXI write address
    output logic [mem_pkg::LANE_IDX_W-1:0]   awid,
    output logic [mem_pkg::ADDR_W-1:0]       awaddr,
    output logic                             awvalid,
    input  wire                              awready,
    // AXI write data
    output logic [mem_pkg::DATA_W-1:0]       wdata,
    output logic [mem_pkg::STRB_W-1:0]       wstrb,
    output logic                             wvalid,
    input  wire                              wready,
    // AXI write response
    input  wire  [mem_pkg::LANE_IDX_W-1:0]   bid,
    input  wire  [1:0]                       bresp,
    input  wire                              bvalid,
    output logic                             bready
);
    import mem_pkg::*;

    logic [LANE_COUNT-1:0]   lane_load;
    logic [LANE_COUNT-1:0]   lane_busy;
    logic [LANE_COUNT-1:0]   lane_grant;
    logic [LANE_COUNT-1:0]   lane_done;
    mem_cmd_t                lane_cmd;
    lane_req_t               lane_reqs [LANE_COUNT];

    req_dispatch i_req_dispatch (
        .aclk      (aclk),
        .reset     (reset),
        .cmd_req   (cmd_req),
        .cmd       (cmd),
        .lane_busy (lane_busy),
        .cmd_ack   (cmd_ack),
        .lane_load (lane_load),
        .lane_cmd  (lane_cmd)
    );

    // One lane per outstanding command, lane index is the AXI ID
    for (genvar g = 0; g < LANE_COUNT; g++) begin : g_lane
        mem_lane i_mem_lane (
            .aclk  (aclk),
            .reset (reset),
            .load  (lane_load[g]),
            .cmd   (lane_cmd),
            .grant (lane_grant[g]),
            .done  (lane_done[g]),
            .req   (lane_reqs[g]),
            .busy  (lane_busy[g])
        );
    end

    axi_arbiter i_axi_arbiter (
        .aclk       (aclk),
        .reset      (reset),
        .lane_reqs  (lane_reqs),
        .lane_grant (lane_grant),
        .lane_done  (lane_done),
        .arid       (arid),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .awid       (awid),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .rid        (rid),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .bid        (bid),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_ready  (rsp_ready)
    );

endmodule

`default_nettype wire

//--- tb_axi_mem.sv
/*
 * Testbench AXI slave memory
 * Single-beat reads and writes with random ready stalls, random response
 * delays returned out of order across IDs, and SLVERR at 0x1000 and up
 */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem (
    input  wire          aclk,
    input  wire          reset,
    input  wire  [0:0]   arid,
    input  wire  [31:0]  araddr,
    input  wire          arvalid,
    output logic         arready,
    output logic [0:0]   rid,
    output logic [31:0]  rdata,
    output logic [1:0]   rresp,
    output logic         rvalid,
    input  wire          rready,
    input  wire  [0:0]   awid,
    input  wire  [31:0]  awaddr,
    input  wire          awvalid,
    output logic         awready,
    input  wire  [31:0]  wdata,
    input  wire  [3:0]   wstrb,
    input  wire          wvalid,
    output logic         wready,
    output logic [0:0]   bid,
    output logic [1:0]   bresp,
    output logic         bvalid,
    input  wire          bready
);
    logic [31:0] mem [logic [31:0]];
    integer      seed = 32'hc624;
    logic        r_pend [2];
    logic [31:0] r_data [2];
    logic [1:0]  r_resp [2];
    int          r_wait [2];
    logic        b_pend [2];
    logic [1:0]  b_resp [2];
    int          b_wait [2];
    logic        aw_got;
    logic        w_got;
    logic [31:0] aw_addr;
    logic [0:0]  aw_id;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic        r_hs;
    logic        b_hs;
    int          start;
    int          k;

    initial begin
        arready = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        rvalid  = 1'b0;
        bvalid  = 1'b0;
        rid     = '0;
        bid     = '0;
        rdata   = '0;
        rresp   = '0;
        bresp   = '0;
        aw_got  = 1'b0;
        w_got   = 1'b0;
        for (int i = 0; i < 2; i++) begin
            r_pend[i] = 1'b0;
            b_pend[i] = 1'b0;
        end
    end

    // Unwritten words read back a pattern built from the full address
    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'h5a3c_96e1;
    endfunction

    always @(posedge aclk) begin
        r_hs = rvalid && rready;
        b_hs = bvalid && bready;
        if (reset) begin
            aw_got = 1'b0;
            w_got  = 1'b0;
            for (int i = 0; i < 2; i++) begin
                r_pend[i] = 1'b0;
                b_pend[i] = 1'b0;
            end
        end else begin
            if (arvalid && arready) begin
                r_pend[arid] = 1'b1;
                r_data[arid] = read_word(araddr);
                r_resp[arid] = (araddr >= 32'h1000) ? 2'd2 : 2'd0;
                r_wait[arid] = $unsigned($random(seed)) % 8;
            end
            if (awvalid && awready) begin
                aw_got  = 1'b1;
                aw_addr = awaddr;
                aw_id   = awid;
            end
            if (wvalid && wready) begin
                w_got  = 1'b1;
                w_data = wdata;
                w_strb = wstrb;
            end
            if (aw_got && w_got) begin
                if (aw_addr < 32'h1000) begin
                    mem[aw_addr] = read_word(aw_addr);
                    for (int b = 0; b < 4; b++) begin
                        if (w_strb[b]) begin
                            mem[aw_addr][8*b +: 8] = w_data[8*b +: 8];
                        end
                    end
                end
                b_pend[aw_id] = 1'b1;
                b_resp[aw_id] = (aw_addr >= 32'h1000) ? 2'd2 : 2'd0;
                b_wait[aw_id] = $unsigned($random(seed)) % 8;
                aw_got = 1'b0;
                w_got  = 1'b0;
            end
            if (r_hs) begin
                r_pend[rid] = 1'b0;
            end
            if (b_hs) begin
                b_pend[bid] = 1'b0;
            end
            for (int i = 0; i < 2; i++) begin
                if (r_wait[i] > 0) r_wait[i]--;
                if (b_wait[i] > 0) b_wait[i]--;
            end
        end
        #1;
        arready = !reset && ($random(seed) & 1);
        awready = !reset && !aw_got && ($random(seed) & 1);
        wready  = !reset && !w_got && ($random(seed) & 1);
        // A beat that was not taken stays on the bus
        if (reset || !rvalid || r_hs) begin
            rvalid = 1'b0;
            start  = $random(seed) & 1;
            for (int i = 0; i < 2; i++) begin
                k = (start + i) % 2;
                if (!reset && !rvalid && r_pend[k] && r_wait[k] == 0) begin
                    rvalid = 1'b1;
                    rid    = k;
                    rdata  = r_data[k];
                    rresp  = r_resp[k];
                end
            end
        end
        if (reset || !bvalid || b_hs) begin
            bvalid = 1'b0;
            start  = $random(seed) & 1;
            for (int i = 0; i < 2; i++) begin
                k = (start + i) % 2;
                if (!reset && !bvalid && b_pend[k] && b_wait[k] == 0) begin
                    bvalid = 1'b1;
                    bid    = k;
                    bresp  = b_resp[k];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_core_top.sv
/*
 * Testbench for the memory subsystem
 * Four-phase command stimulus, reference memory and response checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_core_top;
    import mem_pkg::*;

    logic aclk = 1'b0;
    logic reset;
    logic cmd_req;
    mem_cmd_t cmd;
    logic cmd_ack;
    logic rsp_valid;
    mem_rsp_t rsp;
    logic rsp_ready;
    logic [0:0] arid;
    logic [0:0] rid;
    logic [0:0] awid;
    logic [0:0] bid;
    logic [31:0] araddr;
    logic [31:0] rdata;
    logic [31:0] awaddr;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic [1:0] rresp;
    logic [1:0] bresp;
    logic arvalid;
    logic arready;
    logic rvalid;
    logic rready;
    logic awvalid;
    logic awready;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;

    integer seed = 32'hc624;
    int errors = 0;
    int acked = 0;
    int accepted = 0;
    int rst_cycles = 0;
    int post_cycles = 0;
    logic stall = 1'b0;
    string test_name = "reset";
    logic [31:0] ref_mem [logic [31:0]];
    mem_cmd_t rec_cmd [LANE_COUNT];
    logic outstanding [LANE_COUNT];
    logic prev_req = 1'b0;
    logic prev_ack = 1'b0;
    logic prev_valid = 1'b0;
    logic prev_ready = 1'b0;
    mem_rsp_t prev_rsp;

    always #5 aclk = ~aclk;

    core_top i_core_top (.*);
    tb_axi_mem i_axi_mem (.*);

    // ======================================================================
    // Checks
    // ======================================================================
    always @(posedge aclk) begin
        logic [31:0] exp_data;
        logic [1:0]  exp_resp;
        if (reset) rst_cycles++;
        else post_cycles++;
        if ((reset && rst_cycles > 1) || (!reset && post_cycles == 1)) begin
            assert (!cmd_ack && !arvalid && !awvalid && !wvalid && !rsp_valid) else begin
                errors++;
                $display("outputs not low around reset");
            end
        end
        if (!reset) begin
            assert (!(cmd_ack && !prev_ack && !prev_req)) else begin
                errors++;
                $display("cmd_ack rose while cmd_req was low");
            end
            assert (!(!cmd_ack && prev_ack && prev_req)) else begin
                errors++;
                $display("cmd_ack fell while cmd_req was high");
            end
            if (cmd_ack && !prev_ack) acked++;
            // Back-pressure keeps the response steady
            if (prev_valid && !prev_ready) begin
                assert (rsp_valid) else begin
                    errors++;
                    $display("rsp_valid dropped while rsp_ready was low in %s", test_name);
                end
                assert (rsp == prev_rsp) else begin
                    errors++;
                    $display("mismatch %s stalled rsp: expected %h actual %h", test_name,
                             prev_rsp, rsp);
                end
            end else if (rsp_valid) begin
                // New response, checked against the command of its lane
                assert (outstanding[rsp.tag]) else begin
                    errors++;
                    $display("tag %0d returned with no command loaded", rsp.tag);
                end
                outstanding[rsp.tag] = 1'b0;
                assert (rsp.op == rec_cmd[rsp.tag].op) else begin
                    errors++;
                    $display("mismatch %s op: expected %0d actual %0d", test_name,
                             rec_cmd[rsp.tag].op, rsp.op);
                end
                // SLVERR from 0x1000 up, OKAY below
                exp_resp = (rec_cmd[rsp.tag].addr >= 32'h1000) ? 2'd2 : 2'd0;
                assert (rsp.resp == exp_resp) else begin
                    errors++;
                    $display("mismatch %s resp: expected %0d actual %0d", test_name,
                             exp_resp, rsp.resp);
                end
                if (rsp.op == OP_READ && rec_cmd[rsp.tag].addr < 32'h1000) begin
                    exp_data = ref_mem[rec_cmd[rsp.tag].addr];
                    assert (rsp.rdata == exp_data) else begin
                        errors++;
                        $display("mismatch %s rdata: expected %h actual %h", test_name,
                                 exp_data, rsp.rdata);
                    end
                end
            end
            for (int i = 0; i < LANE_COUNT; i++) begin
                if (i_core_top.lane_load[i]) begin
                    rec_cmd[i]     = cmd;
                    outstanding[i] = 1'b1;
                end
            end
            if (rsp_valid && rsp_ready) accepted++;
            // One more can sit in the response register beside full lanes
            assert (acked - accepted <= LANE_COUNT + 1) else begin
                errors++;
                $display("too many commands in flight: %0d", acked - accepted);
            end
        end
        prev_req   = cmd_req;
        prev_ack   = cmd_ack;
        prev_valid = rsp_valid;
        prev_ready = rsp_ready;
        prev_rsp   = rsp;
    end

    always @(posedge aclk) begin
        #1;
        rsp_ready <= stall ? 1'b0 : (($random(seed) & 3) != 0);
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    task automatic finish_run();
        assert (acked == accepted) else begin
            errors++;
            $display("mismatch %s responses: expected %0d actual %0d", test_name,
                     acked, accepted);
        end
        $display("errors: %0d, commands: %0d, responses: %0d", errors, acked, accepted);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        errors++;
        $display("timeout while waiting for %s in %s", what, test_name);
        finish_run();
    endtask

    task automatic send(input mem_op_e op, input logic [31:0] addr,
                        input logic [31:0] data, input logic [3:0] strb);
        int t;
        logic [31:0] old;
        if (op == OP_WRITE && addr < 32'h1000) begin
            // Unwritten words hold the slave's address-based fill
            old = ref_mem.exists(addr) ? ref_mem[addr] : (addr ^ 32'h5a3c_96e1);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) old[8*b +: 8] = data[8*b +: 8];
            end
            ref_mem[addr] = old;
        end
        @(posedge aclk);
        #1;
        cmd     = '{op: op, addr: addr, wdata: data, wstrb: strb};
        cmd_req = 1'b1;
        t = 0;
        do begin
            @(posedge aclk);
            if (++t > 500) give_up("cmd_ack high");
        end while (!cmd_ack);
        #1;
        cmd_req = 1'b0;
        t = 0;
        do begin
            @(posedge aclk);
            if (++t > 500) give_up("cmd_ack low");
        end while (cmd_ack);
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (acked != accepted || rsp_valid) begin
            @(posedge aclk);
            if (++t > 2000) give_up("all responses");
        end
    endtask

    initial begin
        reset   = 1'b1;
        cmd_req = 1'b0;
        cmd     = '0;
        rsp_ready = 1'b0;
        for (int i = 0; i < LANE_COUNT; i++) outstanding[i] = 1'b0;
        repeat (4) @(posedge aclk);
        #1;
        reset = 1'b0;

        test_name = "write_read";
        for (int i = 0; i < 8; i++) begin
            send(OP_WRITE, 32'h100 + 4*i, 32'hdead_beef ^ (i * 32'h1111_1111), 4'hf);
        end
        for (int i = 0; i < 8; i++) begin
            send(OP_WRITE, 32'h100 + 4*i, 32'h0102_0304 * (i + 3), 4'(i + 1));
        end
        wait_idle();
        for (int i = 0; i < 8; i++) begin
            send(OP_READ, 32'h100 + 4*i, '0, '0);
        end
        wait_idle();

        test_name = "error_region";
        send(OP_WRITE, 32'h1000, 32'h1234_5678, 4'hf);
        send(OP_READ, 32'h1ff0, '0, '0);
        wait_idle();

        test_name = "backpressure";
        stall = 1'b1;
        send(OP_READ, 32'h104, '0, '0);
        send(OP_WRITE, 32'h400, 32'hcafe_f00d, 4'h3);
        repeat (30) @(posedge aclk);
        stall = 1'b0;
        wait_idle();

        // Reads use the settled words, writes their own region
        test_name = "random";
        for (int n = 0; n < 200; n++) begin
            if ($random(seed) & 1) begin
                send(OP_READ, 32'h100 + 4 * ($unsigned($random(seed)) % 8), '0, '0);
            end else if (($random(seed) & 7) == 0) begin
                send(OP_WRITE, 32'h1000 + 4 * ($unsigned($random(seed)) % 64),
                     $random(seed), 4'hf);
            end else begin
                send(OP_WRITE, 32'h400 + 4 * ($unsigned($random(seed)) % 256),
                     $random(seed), 4'($random(seed)));
            end
        end
        wait_idle();
        finish_run();
    end

endmodule

`default_nettype wire

//--- list.f
mem_pkg.sv
req_dispatch.sv
mem_lane.sv
axi_arbiter.sv
core_top.sv
tb_axi_mem.sv
tb_core_top.sv
